// File: filelist.f
common/bus_pkg.sv
common/gpio_map_pkg.sv
bus_cycle/bus_cycle_ctrl.sv
verilog/gpo_regs.sv
verilog/read_path.sv
verilog/gpio_slave_top.sv
tests/gpio_slave_chk.sv
tests/gpio_slave_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the gpio slave testbench with verilator
set -euo pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f filelist.f --top-module gpio_slave_tb -o gpio_slave_sim

status=0
./obj_dir/gpio_slave_sim 2>&1 | tee "$LOG" || status=$?

if [ "$status" -ne 0 ] || grep -q "Errors found" "$LOG"; then
	echo "simulation FAILED, see $LOG"
	exit 1
fi

echo "simulation passed"

// File: tests/gpio_slave_tb.sv
// testbench for the gpio slave
// directed bus accesses checked against a reference model of both windows
`timescale 1ns/100ps
`default_nettype none

module gpio_slave_tb;

	import bus_pkg::*;
	import gpio_map_pkg::*;

	localparam int MAX_CYCLES = 3000;  // ~150 accesses at up to 8 cycles plus margin
	localparam int MAX_WAIT   = 16;    // edges before a missing ready counts as a hang

	logic         BUS_agnt_vi;
	logic         reset;
	logic         valid;
	logic         rnw;
	addr_t        addr;
	data_t        write_data;
	logic         ready;
	logic         error;
	data_t        read_data;
	gpio_vec_t    gp_ip;
	gpio_vec_t    gp_op;
	word_strobe_t gp_op_valid;

	gpio_vec_t   gpo_model;  // expected output vector
	data_t       rd_model;   // expected read_data that holds between reads
	int          cycles = 0;
	int          errors = 0;

	gpio_slave_top gpio_slave_top_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.valid       (valid),
		.rnw         (rnw),
		.addr        (addr),
		.write_data  (write_data),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gp_ip       (gp_ip),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	initial begin
		BUS_agnt_vi = 1'b0;
		forever #5 BUS_agnt_vi = ~BUS_agnt_vi;  // 10 ns period
	end

	// run limit
	always @(posedge BUS_agnt_vi) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Errors found");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reporting
	task automatic stop_with_failure();
		errors++;
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input gpio_vec_t actual,
			input gpio_vec_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	// output window r/w at base+0x00 and input window read only at base+0x20
	function automatic logic is_legal(input logic rd, input addr_t a);
		addr_t off;
		off = a - 32'h0100_0000;
		if (a[1:0] != 2'b00 || a < 32'h0100_0000) return 1'b0;
		if (off < 32'h20) return 1'b1;
		if (off < 32'h40) return rd;  // gpi write is an error
		return 1'b0;
	endfunction

	// one handshake access sampled at the negedge of the ready cycle
	task automatic bus_access(input logic rd, input addr_t a, input data_t wd,
			output int edges, output logic err, output data_t rdata,
			output word_strobe_t strobe, output gpio_vec_t op_vec);
		@(posedge BUS_agnt_vi);
		valid      <= 1'b1;
		rnw        <= rd;
		addr       <= a;
		write_data <= wd;
		edges = 0;
		do begin
			@(posedge BUS_agnt_vi);
			edges++;  // edge 1 is the first one that sees valid
			@(negedge BUS_agnt_vi);
		end while (!ready && edges < MAX_WAIT);
		if (!ready) begin
			$display("no ready from the slave within %0d cycles at %0t", MAX_WAIT, $time);
			stop_with_failure();
		end else begin
			err    = error;
			rdata  = read_data;
			strobe = gp_op_valid;
			op_vec = gp_op;
			@(posedge BUS_agnt_vi);
			valid <= 1'b0;  // master saw ready here
		end
	endtask

	// model update and access, then compare everything visible in the ready cycle
	task automatic run_access(input logic rd, input addr_t a, input data_t wd);
		logic         legal;
		word_idx_t    idx;
		word_strobe_t exp_strobe;
		int           edges;
		logic         err;
		data_t        rdata;
		word_strobe_t strobe;
		gpio_vec_t    op_vec;
		legal      = is_legal(rd, a);
		idx        = a[4:2];
		exp_strobe = '0;
		if (legal && !rd) begin
			gpo_model[idx*DATA_W +: DATA_W] = wd;
			exp_strobe[idx] = 1'b1;
		end else if (legal) begin
			rd_model = a[5] ? gp_ip[idx*DATA_W +: DATA_W] : gpo_model[idx*DATA_W +: DATA_W];
		end
		bus_access(rd, a, wd, edges, err, rdata, strobe, op_vec);
		check_value("wait edges", gpio_vec_t'(edges), gpio_vec_t'(rd ? READ_WAIT : WRITE_WAIT));
		check_value("error", gpio_vec_t'(err), gpio_vec_t'(!legal));
		check_value("gp_op_valid", gpio_vec_t'(strobe), gpio_vec_t'(exp_strobe));
		check_value("gp_op", op_vec, gpo_model);
		check_value("read_data", gpio_vec_t'(rdata), gpio_vec_t'(rd_model));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic check_reset_state();
		check_value("ready", gpio_vec_t'(ready), '0);
		check_value("error", gpio_vec_t'(error), '0);
		check_value("gp_op_valid", gpio_vec_t'(gp_op_valid), '0);
		check_value("gp_op", gp_op, '0);
		check_value("read_data", gpio_vec_t'(read_data), '0);
	endtask

	task automatic test_gpo_write_read();
		for (int i = 0; i < GPIO_WORDS; i++) begin
			run_access(1'b0, addr_t'(GPIO_BASE + i * 4), $urandom);
		end
		for (int i = 0; i < GPIO_WORDS; i++) begin
			run_access(1'b1, addr_t'(GPIO_BASE + i * 4), '0);  // read-back
		end
	endtask

	task automatic test_gpi_reads();
		gpio_vec_t v;
		for (int w = 0; w < GPIO_WORDS; w++) begin
			v[w*DATA_W +: DATA_W] = $urandom;
		end
		@(posedge BUS_agnt_vi);
		gp_ip <= v;
		@(negedge BUS_agnt_vi);  // model sees the new inputs
		for (int i = 0; i < GPIO_WORDS; i++) begin
			run_access(1'b1, addr_t'(GPIO_BASE + 32'h20 + i * 4), '0);
		end
	endtask

	task automatic test_error_cases();
		addr_t bad_addr [6] = '{32'h0100_0024, 32'h0100_003C, 32'h00FF_FFFC,
			32'h0000_0000, 32'h0100_0040, 32'h0200_0000};
		logic  bad_rnw  [6] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
		for (int i = 0; i < 6; i++) begin
			run_access(bad_rnw[i], bad_addr[i], $urandom);
			run_access(1'b1, GPIO_BASE, '0);  // slave still answers normally
		end
	endtask

	task automatic test_random_mix();
		int unsigned delay;
		int unsigned off;
		logic        rd;
		for (int n = 0; n < 100; n++) begin
			delay = $urandom % 4;
			off   = ($urandom % 20) * 4;  // base-8 up to base+0x44
			rd    = 1'($urandom % 2);
			repeat (delay) @(posedge BUS_agnt_vi);
			run_access(rd, GPIO_BASE - 32'd8 + addr_t'(off), $urandom);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		void'($urandom(32'h04e202d4));
		reset      = 1'b1;
		valid      = 1'b0;
		rnw        = 1'b0;
		addr       = '0;
		write_data = '0;
		gp_ip      = '0;
		gpo_model  = '0;
		rd_model   = '0;
		repeat (16) @(posedge BUS_agnt_vi);
		reset <= 1'b0;
		@(negedge BUS_agnt_vi);
		check_reset_state();
		test_gpo_write_read();
		test_gpi_reads();
		test_error_cases();
		test_random_mix();
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/gpio_slave_chk.sv
// protocol checks for the gpio slave
// bound to the top level, watches ready, error and the output valid strobes
`timescale 1ns/100ps
`default_nettype none

module gpio_slave_chk (
	input wire logic                        BUS_agnt_vi,
	input wire logic                        reset,
	input wire logic                        ready,
	input wire logic                        error,
	input wire gpio_map_pkg::word_strobe_t  gp_op_valid
);

	// slave always spends a response cycle, so never two readys in a row
	ready_one_cycle: assert property (@(posedge BUS_agnt_vi) disable iff (reset)
		ready |=> !ready)
		else $error("ready high for two cycles");

	// strobes only with a good write response
	valid_with_ready: assert property (@(posedge BUS_agnt_vi) disable iff (reset)
		(gp_op_valid != '0) |-> (ready && !error))
		else $error("gp_op_valid without a successful ready");

	// sync reset clears everything by the next cycle
	reset_outputs_low: assert property (@(posedge BUS_agnt_vi)
		reset |=> (!ready && !error && gp_op_valid == '0))
		else $error("outputs not low during reset");

endmodule

bind gpio_slave_top gpio_slave_chk gpio_slave_chk_inst (
	.BUS_agnt_vi (BUS_agnt_vi),
	.reset       (reset),
	.ready       (ready),
	.error       (error),
	.gp_op_valid (gp_op_valid)
);

`default_nettype wire

// File: verilog/gpio_slave_top.sv
// gpio slave top level
// bus slave with wait states in front of a 256 bit output / 256 bit input block
`timescale 1ns/100ps
`default_nettype none

module gpio_slave_top (
	input  wire logic                     BUS_agnt_vi,
	input  wire logic                     reset,
	// bus side
	input  wire logic                     valid,
	input  wire logic                     rnw,
	input  wire bus_pkg::addr_t           addr,
	input  wire bus_pkg::data_t           write_data,
	output logic                          ready,
	output logic                          error,
	output bus_pkg::data_t                read_data,
	// gpio side
	input  wire gpio_map_pkg::gpio_vec_t  gp_ip,
	output gpio_map_pkg::gpio_vec_t       gp_op,
	output gpio_map_pkg::word_strobe_t    gp_op_valid
);

	import bus_pkg::*;
	import gpio_map_pkg::*;

	bus_req_t     req;
	wire          bus_rsp_t rsp;
	gpio_access_t access;  // completing access, one cycle

	assign req = '{valid: valid, rnw: rnw, addr: addr, write_data: write_data};

	assign ready     = rsp.ready;
	assign error     = rsp.error;
	assign read_data = rsp.read_data;

	////////////////////////////////////////////////////////////////////////////
	// handshake and decode
	bus_cycle_ctrl bus_cycle_ctrl_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.req         (req),
		.ready       (rsp.ready),
		.error       (rsp.error),
		.access      (access)
	);

	// output words
	gpo_regs gpo_regs_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.access      (access),
		.write_data  (req.write_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	// read mux and register, reads back the live output vector
	read_path read_path_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.access      (access),
		.gp_op       (gp_op),
		.gp_ip       (gp_ip),
		.read_data   (rsp.read_data)
	);

endmodule

`default_nettype wire

// File: verilog/read_path.sv
// read data path of the gpio slave
// picks the addressed output or input word and registers it onto read_data
`timescale 1ns/100ps
`default_nettype none

module read_path (
	input  wire logic                        BUS_agnt_vi,
	input  wire logic                        reset,
	input  wire gpio_map_pkg::gpio_access_t  access,
	input  wire gpio_map_pkg::gpio_vec_t     gp_op,
	input  wire gpio_map_pkg::gpio_vec_t     gp_ip,
	output bus_pkg::data_t                   read_data
);

	import bus_pkg::*;
	import gpio_map_pkg::*;

	gpio_vec_t src;       // window being read
	data_t     rd_word;   // selected word

	// window, then word within it
	always_comb begin
		src     = access.gpi_sel ? gp_ip : gp_op;
		rd_word = src[access.index*DATA_W +: DATA_W];
	end

	////////////////////////////////////////////////////////////////////////////
	// read data register
	// loads only on a legal read and holds otherwise,
	// error responses leave the previous word in place
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			read_data <= '0;
		end else if (access.rd_en) begin
			read_data <= rd_word;  // same edge as ready
		end
	end

endmodule

`default_nettype wire

// File: verilog/gpo_regs.sv
// general purpose output register bank
// eight bus words forming the 256 bit output vector, one valid pulse per write
`timescale 1ns/100ps
`default_nettype none

module gpo_regs (
	input  wire logic                        BUS_agnt_vi,
	input  wire logic                        reset,
	input  wire gpio_map_pkg::gpio_access_t  access,
	input  wire bus_pkg::data_t              write_data,
	output gpio_map_pkg::gpio_vec_t          gp_op,
	output gpio_map_pkg::word_strobe_t       gp_op_valid
);

	import bus_pkg::*;
	import gpio_map_pkg::*;

	word_strobe_t strobe;  // one-hot of the word being written

	always_comb begin
		strobe = '0;
		if (access.wr_en) begin
			strobe = word_strobe_t'(1) << access.index;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output words and valid strobes
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			gp_op       <= '0;  // outputs come up low
			gp_op_valid <= '0;
		end else begin
			gp_op_valid <= strobe;  // access lasts one cycle, so does the pulse
			if (access.wr_en) begin
				gp_op[access.index*DATA_W +: DATA_W] <= write_data;  // other words keep
			end
		end
	end

endmodule

`default_nettype wire

// File: bus_cycle/bus_cycle_ctrl.sv
// bus cycle controller for the gpio slave
// counts wait states, decodes the address, drives ready / error and the access strobe
`timescale 1ns/100ps
`default_nettype none

module bus_cycle_ctrl (
	input  wire logic                   BUS_agnt_vi,
	input  wire logic                   reset,
	input  wire bus_pkg::bus_req_t      req,
	output logic                        ready,
	output logic                        error,
	output gpio_map_pkg::gpio_access_t  access
);

	import bus_pkg::*;
	import gpio_map_pkg::*;

	typedef enum logic [1:0] {
		IDLE,   // waiting for valid
		COUNT,  // wait states running
		RESP    // ready is out, slave takes one cycle off
	} state_t;

	state_t    state;
	wait_cnt_t cnt;       // edges seen so far with valid high
	wait_cnt_t last_cnt;  // count value in the completion cycle
	addr_t     gpo_off;
	addr_t     gpi_off;
	logic      aligned;
	logic      in_gpo;
	logic      in_gpi;
	logic      legal;
	logic      done;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	// offsets wrap below the window base, so one compare covers both bounds
	always_comb begin
		gpo_off = req.addr - (GPIO_BASE + GPO_OFFSET);
		gpi_off = req.addr - (GPIO_BASE + GPI_OFFSET);
		aligned = (req.addr & addr_t'(WORD_BYTES - 1)) == '0;
		in_gpo  = gpo_off < addr_t'(WINDOW_BYTES);
		in_gpi  = gpi_off < addr_t'(WINDOW_BYTES);
		legal   = aligned && (in_gpo || (in_gpi && req.rnw));  // gpi is read only
	end

	// the edge that ends the completion cycle is edge WRITE_WAIT or READ_WAIT
	// both waits are at least 2 since IDLE always accounts for edge 1
	always_comb begin
		last_cnt = req.rnw ? wait_cnt_t'(READ_WAIT - 1) : wait_cnt_t'(WRITE_WAIT - 1);
		done     = (state == COUNT) && req.valid && (cnt == last_cnt);
	end

	// access strobe is live during the completion cycle
	// so the register bank and read path update on the same edge as ready
	always_comb begin
		access         = '0;
		access.gpi_sel = in_gpi;
		access.index   = word_idx_t'(gpo_off >> WORD_LSB);  // both windows share the word bits
		access.wr_en   = done && legal && !req.rnw;
		access.rd_en   = done && legal && req.rnw;
	end

	////////////////////////////////////////////////////////////////////////////
	// wait-state fsm
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			state <= IDLE;
			cnt   <= '0;
			ready <= 1'b0;
			error <= 1'b0;
		end else begin
			ready <= 1'b0;  // low unless set below
			error <= 1'b0;
			case (state)
				IDLE: begin
					if (req.valid) begin  // edge 1 of the access
						state <= COUNT;
						cnt   <= wait_cnt_t'(1);
					end
				end
				COUNT: begin
					if (!req.valid) begin
						state <= IDLE;  // master gave up, nothing happens
					end else if (done) begin
						state <= RESP;
						ready <= 1'b1;
						error <= !legal;  // bad address, misaligned, or gpi write
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RESP: begin
					state <= IDLE;  // ready / error drop here
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: common/gpio_map_pkg.sv
// gpio address map package
// output and input windows, vector types and the per-access decode struct
`default_nettype none

package gpio_map_pkg;

	////////////////////////////////////////////////////////////////////////////
	// address map
	localparam bus_pkg::addr_t GPIO_BASE  = 32'h0100_0000;
	localparam bus_pkg::addr_t GPO_OFFSET = 32'h0000_0000;  // output window, r/w
	localparam bus_pkg::addr_t GPI_OFFSET = 32'h0000_0020;  // input window, read only

	localparam int GPIO_WORDS   = 8;                      // words per window
	localparam int WORD_BYTES   = bus_pkg::DATA_W / 8;
	localparam int WORD_LSB     = $clog2(WORD_BYTES);     // first index bit in addr
	localparam int WINDOW_BYTES = GPIO_WORDS * WORD_BYTES;

	////////////////////////////////////////////////////////////////////////////
	// gpio side types
	typedef logic [$clog2(GPIO_WORDS)-1:0]       word_idx_t;
	typedef logic [GPIO_WORDS-1:0]               word_strobe_t;  // one bit per word
	typedef logic [GPIO_WORDS*bus_pkg::DATA_W-1:0] gpio_vec_t;

	// one completing access, only ever enabled for a legal address
	typedef struct packed {
		logic      wr_en;    // output word write
		logic      rd_en;    // read of either window
		logic      gpi_sel;  // 1 = input window
		word_idx_t index;
	} gpio_access_t;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
// bus package for the gpio slave
// request and response layout, data widths and wait-state counts
`default_nettype none

package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;  // byte address
	typedef logic [DATA_W-1:0] data_t;  // one bus word

	////////////////////////////////////////////////////////////////////////////
	// request from the master, held stable while valid is high
	typedef struct packed {
		logic  valid;
		logic  rnw;         // 1 = read
		addr_t addr;
		data_t write_data;  // don't care on reads
	} bus_req_t;

	// response from the slave
	typedef struct packed {
		logic  ready;      // one cycle pulse
		logic  error;      // qualified by ready
		data_t read_data;  // holds between reads
	} bus_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// wait states, counted as edges with valid sampled high
	localparam int WRITE_WAIT = 3;
	localparam int READ_WAIT  = 4;

	// sized for the longer of the two waits
	typedef logic [$clog2(READ_WAIT+1)-1:0] wait_cnt_t;

endpackage

`default_nettype wire
